// ==== hw/canny_grad_macros.svh ====
`ifndef CANNY_GRAD_MACROS_SVH
`define CANNY_GRAD_MACROS_SVH

// data widths
`define CG_PIXEL_W 8
`define CG_GRAD_W 11
`define CG_MAG_W 12

// tangent ratio in fixed point
`define CG_FRAC_W 16
`define CG_QUOT_W 27
`define CG_TAN22_Q16 27145
`define CG_TAN67_Q16 158217

// direction codes
`define CG_ANG_0 2'd0
`define CG_ANG_45 2'd1
`define CG_ANG_90 2'd2
`define CG_ANG_135 2'd3

`define CG_FIFO_DEPTH 4

`endif

// ==== hw/canny_grad_pkg.sv ====
`include "canny_grad_macros.svh"

package canny_grad_pkg;

  typedef logic [`CG_PIXEL_W-1:0] pixel_t;

  // row-major order with p0 top left and p4 center
  typedef struct packed {
    pixel_t p0;
    pixel_t p1;
    pixel_t p2;
    pixel_t p3;
    pixel_t p4;
    pixel_t p5;
    pixel_t p6;
    pixel_t p7;
    pixel_t p8;
  } window_t;

  typedef struct packed {
    logic signed [`CG_GRAD_W-1:0] gx;
    logic signed [`CG_GRAD_W-1:0] gy;
  } grad_t;

  typedef logic [1:0] angle_t;

  typedef struct packed {
    logic [`CG_MAG_W-1:0] mag;
    angle_t               angle;
  } edge_t;

endpackage

// ==== hw/sobel_kernel.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module sobel_kernel (
  input  logic                    clk,
  input  logic                    rst,
  input  canny_grad_pkg::window_t win,
  input  logic                    win_valid,
  output logic                    win_ready,
  output canny_grad_pkg::grad_t   grad,
  output logic                    grad_valid,
  input  logic                    grad_ready
);

  // column and row sums never exceed 4 * 255
  localparam int sum_w = `CG_GRAD_W - 1;

  logic [sum_w-1:0] left_sum;
  logic [sum_w-1:0] right_sum;
  logic [sum_w-1:0] top_sum;
  logic [sum_w-1:0] bottom_sum;
  logic             active;
  logic             load;

  assign left_sum   = sum_w'(win.p0) + sum_w'({win.p3, 1'b0}) + sum_w'(win.p6);
  assign right_sum  = sum_w'(win.p2) + sum_w'({win.p5, 1'b0}) + sum_w'(win.p8);
  assign top_sum    = sum_w'(win.p0) + sum_w'({win.p1, 1'b0}) + sum_w'(win.p2);
  assign bottom_sum = sum_w'(win.p6) + sum_w'({win.p7, 1'b0}) + sum_w'(win.p8);

  // output register free or draining this cycle
  assign win_ready = active && (!grad_valid || grad_ready);
  assign load      = win_valid && win_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active     <= 1'b0;
      grad_valid <= 1'b0;
    end else begin
      active <= 1'b1;
      if (load) begin
        grad_valid <= 1'b1;
      end else if (grad_ready) begin
        grad_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      grad.gx <= $signed({1'b0, right_sum} - {1'b0, left_sum});
      grad.gy <= $signed({1'b0, bottom_sum} - {1'b0, top_sum});
    end
  end

endmodule

// ==== hw/grad_fifo.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module grad_fifo #(
  parameter int depth = `CG_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst,
  input  canny_grad_pkg::grad_t grad,
  input  logic                  grad_valid,
  output logic                  grad_ready,
  output canny_grad_pkg::grad_t head,
  output logic                  head_valid,
  input  logic                  head_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  canny_grad_pkg::grad_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // wraps at depth even when depth is not a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + ptr_w'(1);
  endfunction

  assign grad_ready = (count != cnt_w'(depth));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign wr_en      = grad_valid && grad_ready;
  assign rd_en      = head_valid && head_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= grad;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous push and pop leaves the count alone
      case ({wr_en, rd_en})
        2'b10: count <= count + cnt_w'(1);
        2'b01: count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/ratio_divider.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module ratio_divider (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic signed [`CG_GRAD_W-1:0] gx,
  input  logic signed [`CG_GRAD_W-1:0] gy,
  output logic                         busy,
  output logic signed [`CG_QUOT_W:0]   quot
);

  localparam int cnt_w = $clog2(`CG_QUOT_W + 1);

  logic [cnt_w-1:0]      steps;
  // dividend bits leave at the top, quotient bits enter at the bottom
  logic [`CG_QUOT_W-1:0] dvd;
  logic [`CG_GRAD_W-1:0] divisor;
  logic [`CG_GRAD_W-1:0] rem;
  logic                  neg;
  logic [`CG_GRAD_W-1:0] abs_gx;
  logic [`CG_GRAD_W-1:0] abs_gy;
  logic [`CG_GRAD_W:0]   trial;
  logic [`CG_GRAD_W:0]   diff;
  logic                  q_bit;

  assign abs_gx = gx[`CG_GRAD_W-1] ? -gx : gx;
  assign abs_gy = gy[`CG_GRAD_W-1] ? -gy : gy;

  // partial remainder with the next dividend bit brought down
  assign trial = {rem, dvd[`CG_QUOT_W-1]};
  assign diff  = trial - {1'b0, divisor};
  assign q_bit = (trial >= {1'b0, divisor});

  assign busy = (steps != '0);

  // sign applied last so the quotient truncates toward zero
  assign quot = neg ? -$signed({1'b0, dvd}) : $signed({1'b0, dvd});

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      steps <= '0;
    end else if (start) begin
      steps <= cnt_w'(`CG_QUOT_W);
    end else if (busy) begin
      steps <= steps - cnt_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dvd     <= {abs_gy, {`CG_FRAC_W{1'b0}}};
      divisor <= abs_gx;
      rem     <= '0;
      neg     <= gx[`CG_GRAD_W-1] ^ gy[`CG_GRAD_W-1];
    end else if (busy) begin
      dvd <= {dvd[`CG_QUOT_W-2:0], q_bit};
      // remainder stays below the divisor, so the top bit is always clear
      if (q_bit) begin
        rem <= diff[`CG_GRAD_W-1:0];
      end else begin
        rem <= trial[`CG_GRAD_W-1:0];
      end
    end
  end

endmodule

// ==== hw/angle_quantizer.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module angle_quantizer (
  input  logic                  clk,
  input  logic                  rst,
  input  canny_grad_pkg::grad_t head,
  input  logic                  head_valid,
  output logic                  head_ready,
  output canny_grad_pkg::edge_t result,
  output logic                  res_valid,
  input  logic                  res_ready
);

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_divide = 2'd1;
  localparam logic [1:0] st_hold   = 2'd2;

  logic [1:0]                   state;
  logic                         start_q;
  canny_grad_pkg::grad_t        pair_q;
  logic [`CG_MAG_W-1:0]         mag_q;
  logic                         gx_zero_q;
  logic                         gy_zero_q;
  logic [`CG_GRAD_W-1:0]        abs_gx;
  logic [`CG_GRAD_W-1:0]        abs_gy;
  logic signed [`CG_GRAD_W-1:0] div_gx;
  logic                         div_busy;
  logic signed [`CG_QUOT_W:0]   quot;
  logic [`CG_QUOT_W:0]          abs_quot;
  canny_grad_pkg::angle_t       dir;
  logic                         accept;
  logic                         finish;

  assign head_ready = (state == st_idle);
  assign res_valid  = (state == st_hold);
  assign accept     = head_valid && head_ready;

  assign abs_gx = head.gx[`CG_GRAD_W-1] ? -head.gx : head.gx;
  assign abs_gy = head.gy[`CG_GRAD_W-1] ? -head.gy : head.gy;

  // zero gx still runs the divider on 1 to keep the latency fixed
  assign div_gx = gx_zero_q ? `CG_GRAD_W'sd1 : pair_q.gx;

  // load cycle has start_q high and busy still low
  assign finish = (state == st_divide) && !start_q && !div_busy;

  ratio_divider ratio_divider_inst (
    .clk   (clk),
    .rst   (rst),
    .start (start_q),
    .gx    (div_gx),
    .gy    (pair_q.gy),
    .busy  (div_busy),
    .quot  (quot)
  );

  assign abs_quot = quot[`CG_QUOT_W] ? -quot : quot;

  always_comb begin
    if (gx_zero_q) begin
      dir = gy_zero_q ? `CG_ANG_0 : `CG_ANG_90;
    end else if (abs_quot <= `CG_TAN22_Q16) begin
      dir = `CG_ANG_0;
    end else if (abs_quot >= `CG_TAN67_Q16) begin
      dir = `CG_ANG_90;
    end else begin
      dir = quot[`CG_QUOT_W] ? `CG_ANG_135 : `CG_ANG_45;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= st_idle;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      case (state)
        st_idle:   if (accept) state <= st_divide;
        st_divide: if (finish) state <= st_hold;
        st_hold:   if (res_ready) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pair_q    <= head;
      mag_q     <= `CG_MAG_W'(abs_gx) + `CG_MAG_W'(abs_gy);
      gx_zero_q <= (head.gx == '0);
      gy_zero_q <= (head.gy == '0);
    end
    if (finish) begin
      result.mag   <= mag_q;
      result.angle <= dir;
    end
  end

endmodule

// ==== hw/canny_grad_top.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module canny_grad_top (
  input  logic                    clk,
  input  logic                    rst,
  input  canny_grad_pkg::window_t win,
  input  logic                    win_valid,
  output logic                    win_ready,
  output canny_grad_pkg::edge_t   result,
  output logic                    res_valid,
  input  logic                    res_ready
);

  canny_grad_pkg::grad_t grad;
  logic                  grad_valid;
  logic                  grad_ready;
  canny_grad_pkg::grad_t head;
  logic                  head_valid;
  logic                  head_ready;

  sobel_kernel sobel_kernel_inst (
    .clk        (clk),
    .rst        (rst),
    .win        (win),
    .win_valid  (win_valid),
    .win_ready  (win_ready),
    .grad       (grad),
    .grad_valid (grad_valid),
    .grad_ready (grad_ready)
  );

  // absorbs gradients while the divider is busy
  grad_fifo #(
    .depth (`CG_FIFO_DEPTH)
  ) grad_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .grad       (grad),
    .grad_valid (grad_valid),
    .grad_ready (grad_ready),
    .head       (head),
    .head_valid (head_valid),
    .head_ready (head_ready)
  );

  angle_quantizer angle_quantizer_inst (
    .clk        (clk),
    .rst        (rst),
    .head       (head),
    .head_valid (head_valid),
    .head_ready (head_ready),
    .result     (result),
    .res_valid  (res_valid),
    .res_ready  (res_ready)
  );

endmodule

// ==== tb/canny_grad_checker.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module canny_grad_checker (
  input logic                    clk,
  input logic                    rst,
  input canny_grad_pkg::window_t win,
  input logic                    win_valid,
  input logic                    win_ready,
  input canny_grad_pkg::edge_t   result,
  input logic                    res_valid,
  input logic                    res_ready,
  input logic                    head_valid,
  input logic                    head_ready
);

  // load, divide steps and quantize, then res_valid is seen on the next edge
  localparam int res_delay = `CG_QUOT_W + 3;

  int error_count = 0;

  win_hold: assert property (@(posedge clk) disable iff (rst)
    win_valid && !win_ready |=> win_valid && $stable(win))
    else begin
      $error("win_valid dropped or win changed while win_ready was low");
      error_count++;
    end

  res_hold: assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(result))
    else begin
      $error("res_valid dropped or result changed while res_ready was low");
      error_count++;
    end

  res_after_reset: assert property (@(posedge clk) $fell(rst) |-> !res_valid)
    else begin
      $error("res_valid high in the first cycle after reset");
      error_count++;
    end

  res_latency: assert property (@(posedge clk) disable iff (rst)
    head_valid && head_ready |-> ##res_delay $rose(res_valid))
    else begin
      $error("res_valid did not rise at the fixed latency after a pair was taken");
      error_count++;
    end

endmodule

bind canny_grad_top canny_grad_checker canny_grad_checker_inst (
  .clk        (clk),
  .rst        (rst),
  .win        (win),
  .win_valid  (win_valid),
  .win_ready  (win_ready),
  .result     (result),
  .res_valid  (res_valid),
  .res_ready  (res_ready),
  .head_valid (head_valid),
  .head_ready (head_ready)
);

// ==== tb/canny_grad_tb.sv ====
`timescale 1ns/10ps

`include "canny_grad_macros.svh"

module canny_grad_tb;

  localparam int clk_period  = 4;
  localparam int n_windows   = 600;
  localparam int n_directed  = 12;
  localparam int burst_len   = 40;
  localparam int watchdog_ns = n_windows * (`CG_QUOT_W + 4) * clk_period * 2;

  logic                    clk;
  logic                    rst;
  canny_grad_pkg::window_t win;
  logic                    win_valid;
  logic                    win_ready;
  canny_grad_pkg::edge_t   result;
  logic                    res_valid;
  logic                    res_ready;

  logic [31:0]             rng;
  canny_grad_pkg::edge_t   expected [$];
  int                      issued;
  int                      received;
  int                      stall_cycles;

  canny_grad_top canny_grad_top_inst (
    .clk       (clk),
    .rst       (rst),
    .win       (win),
    .win_valid (win_valid),
    .win_ready (win_ready),
    .result    (result),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng   = xorshift32(rng);
    value = rng;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // flat, step and diagonal ramp patterns
  function automatic int pattern_pixel(input int kind, input int r, input int c);
    case (kind)
      0: return 0;
      1: return 255;
      2: return 77;
      3: return (c == 2) ? 255 : 0;
      4: return (c == 0) ? 255 : 0;
      5: return (r == 2) ? 255 : 0;
      6: return (r == 0) ? 255 : 0;
      7: return 40 * (r + c);
      8: return 40 * (r + 2 - c);
      9: return 30 * (2 - r + c);
      10: return 30 * (4 - r - c);
      default: return 20 * c + 60 * r;
    endcase
  endfunction

  function automatic canny_grad_pkg::window_t pattern_window(input int kind);
    canny_grad_pkg::window_t w;
    for (int k = 0; k < 9; k++) begin
      w[(8 - k) * `CG_PIXEL_W +: `CG_PIXEL_W] = `CG_PIXEL_W'(pattern_pixel(kind, k / 3, k % 3));
    end
    return w;
  endfunction

  task automatic random_window(output canny_grad_pkg::window_t w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    next_random(a);
    next_random(b);
    next_random(c);
    w = {a, b, c[31:24]};
  endtask

  function automatic canny_grad_pkg::edge_t model_edge(input canny_grad_pkg::window_t w);
    canny_grad_pkg::edge_t e;
    int gx;
    int gy;
    int q;
    int abs_q;
    gx = (int'(w.p2) + 2 * int'(w.p5) + int'(w.p8))
       - (int'(w.p0) + 2 * int'(w.p3) + int'(w.p6));
    gy = (int'(w.p6) + 2 * int'(w.p7) + int'(w.p8))
       - (int'(w.p0) + 2 * int'(w.p1) + int'(w.p2));
    e.mag = `CG_MAG_W'((gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy));
    if (gx == 0) begin
      e.angle = (gy == 0) ? `CG_ANG_0 : `CG_ANG_90;
    end else begin
      // int division truncates toward zero
      q     = (gy * (1 << `CG_FRAC_W)) / gx;
      abs_q = (q < 0) ? -q : q;
      if (abs_q <= `CG_TAN22_Q16) begin
        e.angle = `CG_ANG_0;
      end else if (abs_q >= `CG_TAN67_Q16) begin
        e.angle = `CG_ANG_90;
      end else begin
        e.angle = (q > 0) ? `CG_ANG_45 : `CG_ANG_135;
      end
    end
    return e;
  endfunction

  task automatic check_result();
    canny_grad_pkg::edge_t exp_edge;
    assert (expected.size() > 0)
      else report_failure("a result arrived with no window outstanding");
    exp_edge = expected.pop_front();
    assert (result.mag == exp_edge.mag)
      else report_failure($sformatf("Error result.mag expected %h actual %h",
                                    exp_edge.mag, result.mag));
    assert (result.angle == exp_edge.angle)
      else report_failure($sformatf("Error result.angle expected %h actual %h",
                                    exp_edge.angle, result.angle));
    received++;
  endtask

  always @(posedge clk) begin : drive_and_check
    logic [31:0]             dice;
    canny_grad_pkg::window_t next_win;
    if (!rst) begin
      assert (canny_grad_top_inst.canny_grad_checker_inst.error_count == 0)
        else report_failure("a checker assertion on handshake or latency failed");
      if (res_valid && res_ready) begin
        check_result();
      end
      if (win_valid && !win_ready) begin
        stall_cycles++;
      end
      if (win_valid && win_ready) begin
        expected.push_back(model_edge(win));
      end
      if (!win_valid || win_ready) begin
        next_random(dice);
        // odd stretches are back-to-back bursts
        if (issued < n_windows && ((issued / burst_len) % 2 == 1 || dice[0])) begin
          if (issued < n_directed) begin
            win <= pattern_window(issued);
          end else begin
            random_window(next_win);
            win <= next_win;
          end
          win_valid <= 1'b1;
          issued++;
        end else begin
          win_valid <= 1'b0;
        end
      end
      next_random(dice);
      res_ready <= dice[8];
    end
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    win          = '0;
    win_valid    = 1'b0;
    res_ready    = 1'b0;
    rng          = 32'h754a79ec;
    issued       = 0;
    received     = 0;
    stall_cycles = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait (received == n_windows);
    // quiet stretch to catch a duplicated result
    repeat (2 * (`CG_QUOT_W + 3)) @(posedge clk);
    if (expected.size() == 0 && stall_cycles > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_failure($sformatf(
        "run ended with %0d results missing and %0d stalled input cycles",
        expected.size(), stall_cycles));
    end
  end

  initial begin
    #(watchdog_ns);
    report_failure($sformatf("timeout: results stopped arriving, %0d of %0d received",
                             received, n_windows));
  end

endmodule

// ==== canny_grad.f ====
+incdir+hw
hw/canny_grad_pkg.sv
hw/sobel_kernel.sv
hw/grad_fifo.sv
hw/ratio_divider.sv
hw/angle_quantizer.sv
hw/canny_grad_top.sv
tb/canny_grad_checker.sv
tb/canny_grad_tb.sv
